//--- bench/output_path_chk.sv
`include "lock_macros.svh"

module output_path_chk (
	input	logic							clk_in,			// preprocessor clock
	input	logic							reset_in,		// async reset, active high
	input	logic							data_valid_out,	// result strobe
	input	logic signed [`LOCK_OUT_W-1:0]	data_out,		// clamped result
	input	lock_pkg::out_params_t			active_params	// window in use
);
	timeunit 1ns;
	timeprecision 1ps;
	import lock_pkg::*;

	////////////////////////////////////////////////////////////
	// output strobe
	////////////////////////////////////////////////////////////

	a_valid_single: assert property (@(posedge clk_in) disable iff (reset_in)
		data_valid_out |=> !data_valid_out)	// one cycle per result
		else $error("data_valid_out held for more than one cycle");

	a_valid_reset: assert property (@(posedge clk_in) reset_in |-> !data_valid_out)
		else $error("data_valid_out high during reset");

	////////////////////////////////////////////////////////////
	// window
	////////////////////////////////////////////////////////////

	a_in_window: assert property (@(posedge clk_in) disable iff (reset_in)
		(data_valid_out && $signed(active_params.out_min) <= $signed(active_params.out_max))
		|-> ($signed(data_out) >= $signed(active_params.out_min)
			&& $signed(data_out) <= $signed(active_params.out_max)))
		else $error("data_out outside the output window");	// normal window only

endmodule

bind output_preprocessor output_path_chk u_output_path_chk (
	.clk_in			(clk_in),
	.reset_in		(reset_in),
	.data_valid_out	(data_valid_out),
	.data_out		(data_out),
	.active_params	(active_params)
);

//--- bench/output_path_tb.sv
`include "lock_macros.svh"

module output_path_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import lock_pkg::*;

	localparam int COMP_LATENCY = 2;	// cycles in ST_COMPUTE
	localparam int LATENCY = 1 + COMP_LATENCY;	// mux register plus compute cycles
	localparam int TIMEOUT_CYCLES = 16;	// longest wait for one result

	logic							clk_in = 1'b0;
	logic							reset_in;
	lock_sample_t					ch_samples [`LOCK_N_CH];	// all error channels
	logic [`LOCK_SEL_W-1:0]			ch_sel;
	out_params_t					cfg_params;	// front-panel values
	logic							update_en;
	logic							update;
	logic signed [`LOCK_OUT_W-1:0]	data_out;
	logic							data_valid_out;

	int tests_run;		// finished tests
	int tests_failed;	// tests with at least one error
	int errors;			// every failed check

	output_path_top #(
		.COMP_LATENCY	(COMP_LATENCY)
	) u_output_path_top (
		.clk_in			(clk_in),
		.reset_in		(reset_in),
		.ch_samples		(ch_samples),
		.ch_sel			(ch_sel),
		.cfg_params		(cfg_params),
		.update_en		(update_en),
		.update			(update),
		.data_out		(data_out),
		.data_valid_out	(data_valid_out)
	);

	initial begin
		forever #50 clk_in = ~clk_in;	// 100 ns period
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic finish_test(input string name, input int bad);
		tests_run++;
		errors += bad;
		if (bad > 0) begin
			tests_failed++;
		end
		$display("test %0d %s: %s", tests_run, name, (bad > 0) ? "failed" : "passed");
	endtask

	task automatic scramble_channels();
		for (int i = 0; i < `LOCK_N_CH; i++) begin
			ch_samples[i].data = `LOCK_IN_W'($urandom);	// noise on idle data
			ch_samples[i].valid = 1'b0;
		end
	endtask

	task automatic apply_reset();
		int bad;
		bad = 0;
		reset_in = 1'b1;
		repeat (4) @(negedge clk_in);	// four cycles of reset
		reset_in = 1'b0;
		for (int k = 0; k < 4; k++) begin	// bounded watch after release
			@(negedge clk_in);
			if (data_valid_out !== 1'b0 || data_out !== '0) begin
				$display("ERROR at %0t: after reset valid %b data_out %0d", $time,
					data_valid_out, data_out);
				bad++;
			end
		end
		finish_test("reset", bad);
	endtask

	task automatic load_config(input int max_v, input int min_v, input int init_v,
		input int gain, input int en, input int upd);
		cfg_params.out_max = `LOCK_OUT_W'(max_v);
		cfg_params.out_min = `LOCK_OUT_W'(min_v);
		cfg_params.out_init = `LOCK_OUT_W'(init_v);
		cfg_params.multiplier = `LOCK_MULT_W'(gain);
		update_en = (en != 0);	// level held until the next record
		update = (upd != 0);
		@(negedge clk_in);
		update = 1'b0;	// single pulse
		repeat (2) @(negedge clk_in);	// init_load and reseed
		$display("config max %0d min %0d init %0d gain %0d en %0d update %0d",
			max_v, min_v, init_v, gain, en, upd);
	endtask

	task automatic run_sample(input int ch, input int sel, input int val,
		input bit expect_out, input int exp_val);
		int bad;
		int lat;
		bit seen;
		logic signed [`LOCK_OUT_W-1:0] got;
		bad = 0;
		lat = 0;
		seen = 1'b0;
		got = '0;
		scramble_channels();
		ch_sel = sel[`LOCK_SEL_W-1:0];
		ch_samples[ch].data = val[`LOCK_IN_W-1:0];
		ch_samples[ch].valid = 1'b1;	// strobe for one cycle
		for (int k = 1; k <= TIMEOUT_CYCLES && !seen; k++) begin
			@(negedge clk_in);
			if (k == 1) begin
				scramble_channels();	// drop the strobe
			end
			if (data_valid_out) begin
				seen = 1'b1;
				lat = k - 1;	// edges after the strobe edge
				got = data_out;
			end
		end
		if (expect_out) begin
			if (!seen) begin
				$display("no result came within %0d cycles of the strobe on channel %0d",
					TIMEOUT_CYCLES, ch);
				bad++;
			end else begin
				if (lat != LATENCY) begin
					$display("ERROR at %0t: latency %0d, expected %0d", $time, lat, LATENCY);
					bad++;
				end
				if (got !== `LOCK_OUT_W'(exp_val)) begin
					$display("ERROR at %0t: data_out %0d, expected %0d", $time, got, exp_val);
					bad++;
				end
				repeat (2) @(negedge clk_in);	// wait out send and done
			end
		end else if (seen) begin
			$display("ERROR at %0t: unexpected result %0d from channel %0d", $time, got, ch);
			bad++;
		end
		finish_test($sformatf("sample ch %0d sel %0d value %0d", ch, sel, val), bad);
	endtask

	////////////////////////////////////////////////////////////
	// pattern player
	////////////////////////////////////////////////////////////

	initial begin
		int fd;
		int n;
		int ch;
		int sel;
		int val;
		int exp_val;
		int a;
		int b;
		int c;
		int d;
		int e;
		int f;
		logic [8*160-1:0] line_buf;
		logic [8*8-1:0] kind_tok;
		logic [8*8-1:0] exp_tok;
		void'($urandom(32'h6a7));	// fixed seed
		reset_in = 1'b1;
		ch_sel = '0;
		cfg_params = '0;
		update_en = 1'b0;
		update = 1'b0;
		scramble_channels();
		tests_run = 0;
		tests_failed = 0;
		errors = 0;
		apply_reset();
		fd = $fopen("bench/output_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file bench/output_patterns.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line_buf, fd) == 0) begin
					break;
				end
				kind_tok = '0;
				n = $sscanf(line_buf, "%s", kind_tok);
				if (n < 1 || kind_tok == "#") begin
					continue;	// blank or comment
				end
				if (kind_tok == "C") begin
					n = $sscanf(line_buf, "%s %d %d %d %d %d %d", kind_tok, a, b, c, d, e, f);
					if (n == 7) begin
						load_config(a, b, c, d, e, f);
					end else begin
						$display("a config record in the pattern file could not be read");
						errors++;
					end
				end else if (kind_tok == "S") begin
					n = $sscanf(line_buf, "%s %d %d %d %d", kind_tok, ch, sel, val, exp_val);
					exp_tok = '0;
					if (n == 4) begin
						n = $sscanf(line_buf, "%s %d %d %d %s", kind_tok, ch, sel, val, exp_tok);
					end
					if (ch < 0 || ch >= `LOCK_N_CH || n != 5) begin
						$display("a sample record in the pattern file could not be read");
						errors++;
					end else if (exp_tok == "none") begin
						run_sample(ch, sel, val, 1'b0, 0);
					end else begin
						run_sample(ch, sel, val, 1'b1, exp_val);
					end
				end else if (kind_tok == "R") begin
					apply_reset();
				end else begin
					$display("the pattern file holds a record of unknown kind");
					errors++;
				end
			end
			$fclose(fd);
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- bench/output_patterns.txt
# C out_max out_min out_init multiplier update_en update
# S channel select value expected|none ; R reset
C 100000 -100000 1000 3 1 1
S 0 0 10 1030
S 0 0 -20 970
S 0 0 100 1270
S 0 0 -500 -230
C 100000 -100000 0 127 1 1
S 0 0 32767 100000
S 0 0 -32768 -100000
S 0 0 1000 27000
C -50 50 0 1 1 1
S 0 0 5 50
S 0 0 -200 50
C 100000 -100000 1000 3 1 1
S 1 1 10 1030
C 5 5 7777 100 0 1
S 1 1 10 1060
C 5 5 7777 100 1 0
S 1 1 -10 1030
C 100000 -100000 -2000 2 1 1
S 1 1 50 -1900
S 2 1 500 none
S 3 1 500 none
S 1 1 1 -1898
S 3 3 -100 -2098
S 1 3 5 none
R
S 0 0 1000 0
C 10 -10 0 1 1 1
S 2 2 20 10

//--- run_sim.sh
#!/bin/sh
# build the output path testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module output_path_tb -f sources.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/Voutput_path_tb)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Test OK"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- source/channel_mux.sv
`include "lock_macros.svh"

module channel_mux (
	input	logic						clk_in,					// system clock
	input	logic						reset_in,				// async reset, active high
	input	lock_pkg::lock_sample_t		ch_samples [`LOCK_N_CH],	// all error channels
	input	logic [`LOCK_SEL_W-1:0]		ch_sel,					// channel to pass on
	output	lock_pkg::lock_sample_t		sel_sample				// selected channel, one cycle late
);
	import lock_pkg::*;

	////////////////////////////////////////////////////////////
	// channel select
	////////////////////////////////////////////////////////////

	lock_sample_t					picked;		// selected channel, unregistered
	logic signed [`LOCK_IN_W-1:0]	sel_data;	// registered payload
	logic							sel_valid;	// registered strobe

	assign picked = ch_samples[ch_sel];	// select takes effect at the next edge

	////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////

	// strobe register, cleared so nothing stale leaks out of reset
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			sel_valid <= 1'b0;
		end else begin
			sel_valid <= picked.valid;	// only the selected strobe gets through
		end
	end

	// payload follows the selected channel every cycle
	always_ff @(posedge clk_in) begin
		sel_data <= picked.data;
	end

	assign sel_sample = '{data: sel_data, valid: sel_valid};	// repack for the preprocessor

endmodule

//--- source/lock_macros.svh
`ifndef LOCK_MACROS_SVH
`define LOCK_MACROS_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

`define LOCK_IN_W	16	// error sample width, signed
`define LOCK_OUT_W	24	// output word width, signed
`define LOCK_MULT_W	8	// gain factor width, signed

////////////////////////////////////////////////////////////
// input channels
////////////////////////////////////////////////////////////

`define LOCK_N_CH	4	// error channels into the mux
`define LOCK_SEL_W	2	// select width, covers LOCK_N_CH

`endif

//--- source/lock_pkg.sv
`include "lock_macros.svh"

package lock_pkg;

	////////////////////////////////////////////////////////////
	// error sample
	////////////////////////////////////////////////////////////

	// one channel of the error bus, 17 bits
	typedef struct packed {
		logic signed [`LOCK_IN_W-1:0]	data;	// error value
		logic							valid;	// one cycle strobe
	} lock_sample_t;

	////////////////////////////////////////////////////////////
	// front-panel parameters
	////////////////////////////////////////////////////////////

	// output stage settings, 80 bits
	typedef struct packed {
		logic signed [`LOCK_OUT_W-1:0]	out_max;	// window upper bound
		logic signed [`LOCK_OUT_W-1:0]	out_min;	// window lower bound
		logic signed [`LOCK_OUT_W-1:0]	out_init;	// integrator seed value
		logic signed [`LOCK_MULT_W-1:0]	multiplier;	// gain per sample
	} out_params_t;

	////////////////////////////////////////////////////////////
	// preprocessor states
	////////////////////////////////////////////////////////////

	// one pass per accepted sample
	typedef enum logic [1:0] {
		ST_IDLE		= 2'd0,	// wait for a valid sample
		ST_COMPUTE	= 2'd1,	// gain, accumulate, clamp
		ST_SEND		= 2'd2,	// result valid downstream
		ST_DONE		= 2'd3	// result becomes prev
	} pre_state_e;

endpackage

//--- source/output_config_regs.sv
module output_config_regs (
	input	logic					clk_in,			// system clock
	input	logic					reset_in,		// async reset, active high
	input	lock_pkg::out_params_t	cfg_params,		// front-panel values
	input	logic					update_en,		// arms the update pulse
	input	logic					update,			// load request, one cycle
	output	lock_pkg::out_params_t	active_params,	// settings in use
	output	logic					init_load		// integrator reseed, cycle after a load
);

	////////////////////////////////////////////////////////////
	// update gate
	////////////////////////////////////////////////////////////

	logic load_params;	// gated update

	// an update without update_en is ignored completely
	assign load_params = update & update_en;

	////////////////////////////////////////////////////////////
	// parameter bank
	////////////////////////////////////////////////////////////

	// all four fields move together on a gated update
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			active_params <= '0;	// zero window, zero gain
		end else if (load_params) begin
			active_params <= cfg_params;	// bounds, seed and gain
		end
	end

	////////////////////////////////////////////////////////////
	// reseed pulse
	////////////////////////////////////////////////////////////

	// One cycle after the load, so the preprocessor picks up the
	// new out_init from active_params and not the old value.
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			init_load <= 1'b0;
		end else begin
			init_load <= load_params;	// single pulse per gated update
		end
	end

endmodule

//--- source/output_path_top.sv
`include "lock_macros.svh"

module output_path_top #(
	parameter int COMP_LATENCY = 2	// passed to the preprocessor
)(
	input	logic							clk_in,					// system clock
	input	logic							reset_in,				// async reset, active high
	input	lock_pkg::lock_sample_t			ch_samples [`LOCK_N_CH],	// error channels
	input	logic [`LOCK_SEL_W-1:0]			ch_sel,					// active channel
	input	lock_pkg::out_params_t			cfg_params,				// front-panel values
	input	logic							update_en,				// update arm level
	input	logic							update,					// update pulse
	output	logic signed [`LOCK_OUT_W-1:0]	data_out,				// correction word
	output	logic							data_valid_out			// result strobe
);
	import lock_pkg::*;

	////////////////////////////////////////////////////////////
	// internal wires
	////////////////////////////////////////////////////////////

	lock_sample_t	sel_sample;		// mux to preprocessor
	out_params_t	active_params;	// config bank to preprocessor
	logic			init_load;		// reseed pulse

	////////////////////////////////////////////////////////////
	// instances
	////////////////////////////////////////////////////////////

	channel_mux u_channel_mux (
		.clk_in		(clk_in),
		.reset_in	(reset_in),
		.ch_samples	(ch_samples),
		.ch_sel		(ch_sel),
		.sel_sample	(sel_sample)
	);

	output_config_regs u_output_config_regs (
		.clk_in			(clk_in),
		.reset_in		(reset_in),
		.cfg_params		(cfg_params),
		.update_en		(update_en),
		.update			(update),
		.active_params	(active_params),
		.init_load		(init_load)
	);

	output_preprocessor #(
		.COMP_LATENCY	(COMP_LATENCY)
	) u_output_preprocessor (
		.clk_in			(clk_in),
		.reset_in		(reset_in),
		.sel_sample		(sel_sample),
		.active_params	(active_params),
		.init_load		(init_load),
		.data_out		(data_out),
		.data_valid_out	(data_valid_out)
	);

endmodule

//--- source/output_preprocessor.sv
`include "lock_macros.svh"

module output_preprocessor #(
	parameter int COMP_LATENCY = 2	// cycles in ST_COMPUTE, at least 1
)(
	input	logic							clk_in,			// system clock
	input	logic							reset_in,		// async reset, active high
	input	lock_pkg::lock_sample_t			sel_sample,		// selected error sample
	input	lock_pkg::out_params_t			active_params,	// window, seed and gain
	input	logic							init_load,		// reseed prev with out_init
	output	logic signed [`LOCK_OUT_W-1:0]	data_out,		// clamped integrator output
	output	logic							data_valid_out	// one cycle per result
);
	import lock_pkg::*;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	localparam int PROD_W = `LOCK_IN_W + `LOCK_MULT_W;	// full product
	localparam int SUM_W = ((PROD_W > `LOCK_OUT_W) ? PROD_W : `LOCK_OUT_W) + 1;	// carry bit
	localparam int CNT_W = (COMP_LATENCY > 1) ? $clog2(COMP_LATENCY) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(COMP_LATENCY - 1);	// last compute cycle

	////////////////////////////////////////////////////////////
	// internal signals
	////////////////////////////////////////////////////////////

	pre_state_e						cur_state;		// current state
	pre_state_e						next_state;		// next state
	logic [CNT_W-1:0]				counter;		// intrastate counter
	logic							compute_last;	// final compute cycle

	logic signed [`LOCK_IN_W-1:0]	lock_data_raw;	// latched sample
	logic signed [`LOCK_OUT_W-1:0]	data_out_prev;	// integrator state

	logic signed [PROD_W-1:0]		lock_prod;		// sample times gain
	logic signed [SUM_W-1:0]		lock_sum;		// exact prev plus product
	logic signed [SUM_W-1:0]		bound_max;		// out_max, widened
	logic signed [SUM_W-1:0]		bound_min;		// out_min, widened
	logic signed [SUM_W-1:0]		lock_upper;		// after upper clamp
	logic signed [SUM_W-1:0]		lock_clamped;	// after lower clamp
	logic							above_max;		// sum over upper bound
	logic							below_min;		// under lower bound

	////////////////////////////////////////////////////////////
	// gain, accumulate, clamp
	////////////////////////////////////////////////////////////

	assign lock_prod = $signed(lock_data_raw) * $signed(active_params.multiplier);	// no overflow
	assign lock_sum = SUM_W'(lock_prod) + SUM_W'(data_out_prev);	// sign extended, exact

	assign bound_max = SUM_W'($signed(active_params.out_max));
	assign bound_min = SUM_W'($signed(active_params.out_min));

	// upper bound first, then lower, so out_min wins on an inverted window
	assign above_max = lock_sum > bound_max;
	assign lock_upper = above_max ? bound_max : lock_sum;
	assign below_min = lock_upper < bound_min;
	assign lock_clamped = below_min ? bound_min : lock_upper;

	////////////////////////////////////////////////////////////
	// data registers
	////////////////////////////////////////////////////////////

	// sample latched only when a pass starts
	always_ff @(posedge clk_in) begin
		if (cur_state == ST_IDLE && sel_sample.valid) begin
			lock_data_raw <= sel_sample.data;
		end
	end

	// integrator state, init_load wins over the done update
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			data_out_prev <= '0;
		end else if (init_load) begin
			data_out_prev <= active_params.out_init;	// reseed
		end else if (cur_state == ST_DONE) begin
			data_out_prev <= data_out;	// integrate
		end
	end

	// result register, held until the next pass
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			data_out <= '0;
		end else if (cur_state == ST_COMPUTE && compute_last) begin
			data_out <= lock_clamped[`LOCK_OUT_W-1:0];	// fits, value is inside the window
		end
	end

	assign data_valid_out = (cur_state == ST_SEND);	// decoded from state

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////

	assign compute_last = (counter == CNT_LAST);

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			cur_state <= ST_IDLE;
		end else begin
			cur_state <= next_state;
		end
	end

	// counts compute cycles, zero everywhere else
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			counter <= '0;
		end else if (cur_state == ST_COMPUTE && !compute_last) begin
			counter <= counter + 1'b1;
		end else begin
			counter <= '0;
		end
	end

	always_comb begin
		next_state = cur_state;	// hold by default
		case (cur_state)
			ST_IDLE: begin
				if (sel_sample.valid) begin
					next_state = ST_COMPUTE;	// strobes elsewhere are dropped
				end
			end
			ST_COMPUTE: begin
				if (compute_last) begin
					next_state = ST_SEND;
				end
			end
			ST_SEND: next_state = ST_DONE;	// single valid cycle
			ST_DONE: next_state = ST_IDLE;	// prev updated here
			default: next_state = ST_IDLE;
		endcase
	end

endmodule

//--- sources.f
+incdir+source
source/lock_pkg.sv
source/channel_mux.sv
source/output_config_regs.sv
source/output_preprocessor.sv
source/output_path_top.sv
bench/output_path_chk.sv
bench/output_path_tb.sv
